/* logic/zhxpu_pkg.sv */
`default_nettype none

package zhxpu_pkg;

	// One data or instruction word
	typedef logic [15:0] word_t;

	// SRAM word address
	typedef logic [17:0] ram_addr_t;

	// Flash word address
	typedef logic [22:0] flash_addr_t;

	// Single SRAM access as seen by the memory controller
	typedef struct packed {
		ram_addr_t addr;
		word_t wdata;
		logic we;
	} mem_req_t;

	// Segments g f e d c b a, lit when high
	typedef logic [6:0] seg_t;

endpackage

`default_nettype wire

/* logic/flash_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module flash_ctrl import zhxpu_pkg::*; #(
	parameter int FLASH_WAIT = 3
) (
	input wire raw_clk,
	input wire rst_n,
	input wire rd_req,
	input flash_addr_t rd_addr,
	output logic rd_done,
	output word_t rd_data,
	output flash_addr_t flash_addr,
	input word_t flash_data,
	output logic flash_ce,
	output logic flash_oe
);

	localparam int CNT_W = (FLASH_WAIT > 1) ? $clog2(FLASH_WAIT) : 1;

	typedef enum logic [1:0] {
		S_IDLE,
		S_WAIT,
		S_DONE
	} state_t;

	state_t state;
	logic [CNT_W-1:0] cnt;
	flash_addr_t addr_q;
	word_t data_q;
	logic start;
	logic sample;

	assign start = (state == S_IDLE) && rd_req;

	// Last cycle of the enable window
	assign sample = (start && FLASH_WAIT == 0) ||
		(state == S_WAIT && cnt == CNT_W'(FLASH_WAIT - 1));

	// Chip enabled from the request cycle itself
	assign flash_ce = start || (state == S_WAIT);
	assign flash_oe = flash_ce;
	assign flash_addr = (state == S_IDLE) ? rd_addr : addr_q;

	assign rd_done = (state == S_DONE);
	assign rd_data = data_q;

	always_ff @(posedge raw_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			cnt <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					cnt <= '0;
					if (sample)
						state <= S_DONE;
					else if (start)
						state <= S_WAIT;
				end
				S_WAIT: begin
					if (sample)
						state <= S_DONE;
					else
						cnt <= cnt + 1'b1;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge raw_clk) begin
		if (start)
			addr_q <= rd_addr;
		if (sample)
			data_q <= flash_data;
	end

endmodule

`default_nettype wire

/* logic/bootloader.sv */
`timescale 1ns/1ps
`default_nettype none

module bootloader import zhxpu_pkg::*; #(
	parameter int BOOT_WORDS = 64
) (
	input wire raw_clk,
	input wire rst_n,
	output logic rd_req,
	output flash_addr_t rd_addr,
	input wire rd_done,
	input word_t rd_data,
	output logic boot_need,
	output mem_req_t boot_req,
	input wire boot_done_pulse,
	output logic boot_done,
	output ram_addr_t boot_addr
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_READ,
		S_WRITE,
		S_DONE
	} state_t;

	state_t state;
	ram_addr_t idx;
	word_t word_q;

	assign rd_req = (state == S_READ);
	assign rd_addr = flash_addr_t'(idx);

	assign boot_need = (state == S_WRITE);
	assign boot_req = '{addr: idx, wdata: word_q, we: 1'b1};

	assign boot_done = (state == S_DONE);
	assign boot_addr = idx;

	always_ff @(posedge raw_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			idx <= '0;
		end else begin
			case (state)
				// One quiet cycle out of reset
				S_IDLE: state <= S_READ;
				S_READ: begin
					if (rd_done)
						state <= S_WRITE;
				end
				S_WRITE: begin
					if (boot_done_pulse) begin
						if (idx == ram_addr_t'(BOOT_WORDS - 1)) begin
							state <= S_DONE;
						end else begin
							idx <= idx + 1'b1;
							state <= S_READ;
						end
					end
				end
				// Stays here until reset
				default: state <= S_DONE;
			endcase
		end
	end

	// Flash word held for the SRAM write
	always_ff @(posedge raw_clk) begin
		if (state == S_READ && rd_done)
			word_q <= rd_data;
	end

endmodule

`default_nettype wire

/* logic/ram_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ram_ctrl import zhxpu_pkg::*; (
	input wire raw_clk,
	input wire rst_n,
	input wire boot_done,
	input wire boot_need,
	input mem_req_t boot_req,
	output logic boot_done_pulse,
	input wire data_need,
	input mem_req_t data_req,
	output logic data_done,
	output word_t data_rdata,
	input wire fetch_need,
	input ram_addr_t fetch_addr,
	output logic fetch_done,
	output word_t fetch_inst,
	output logic hold,
	output ram_addr_t ram_addr,
	output word_t ram_wdata,
	input word_t ram_rdata,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_ACCESS,
		S_DONE
	} state_t;

	typedef enum logic [1:0] {
		G_BOOT,
		G_DATA,
		G_FETCH
	} grant_t;

	state_t state;
	grant_t grant;
	grant_t pick;
	logic pick_valid;
	mem_req_t pick_req;
	mem_req_t req_q;
	word_t rdata_q;

	// Fixed priority with CPU ports locked out until boot is over
	always_comb begin
		pick_valid = 1'b1;
		pick = G_BOOT;
		pick_req = boot_req;
		if (boot_need) begin
			pick = G_BOOT;
			pick_req = boot_req;
		end else if (boot_done && data_need) begin
			pick = G_DATA;
			pick_req = data_req;
		end else if (boot_done && fetch_need) begin
			pick = G_FETCH;
			pick_req = '{addr: fetch_addr, wdata: '0, we: 1'b0};
		end else begin
			pick_valid = 1'b0;
		end
	end

	always_ff @(posedge raw_clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_IDLE;
			grant <= G_BOOT;
		end else begin
			case (state)
				S_IDLE: begin
					if (pick_valid) begin
						grant <= pick;
						state <= S_ACCESS;
					end
				end
				S_ACCESS: state <= S_DONE;
				// Back to idle so a held request counts as new next cycle
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge raw_clk) begin
		if (state == S_IDLE && pick_valid)
			req_q <= pick_req;
		if (state == S_ACCESS)
			rdata_q <= ram_rdata;
	end

	// SRAM strobes only in the access cycle
	assign ram_en = (state == S_ACCESS);
	assign ram_oe = ram_en && !req_q.we;
	assign ram_we = ram_en && req_q.we;
	assign ram_addr = req_q.addr;
	assign ram_wdata = req_q.wdata;

	assign boot_done_pulse = (state == S_DONE) && (grant == G_BOOT);
	assign data_done = (state == S_DONE) && (grant == G_DATA);
	assign fetch_done = (state == S_DONE) && (grant == G_FETCH);

	assign data_rdata = rdata_q;
	assign fetch_inst = rdata_q;

	// Pipeline stall while booting or while a data access is open
	assign hold = !boot_done || (data_need && !data_done);

endmodule

`default_nettype wire

/* logic/dig_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dig_ctrl import zhxpu_pkg::*; (
	input wire [3:0] dig,
	output seg_t light
);

	// gfedcba
	always_comb begin
		case (dig)
			4'h0: light = 7'h3f;
			4'h1: light = 7'h06;
			4'h2: light = 7'h5b;
			4'h3: light = 7'h4f;
			4'h4: light = 7'h66;
			4'h5: light = 7'h6d;
			4'h6: light = 7'h7d;
			4'h7: light = 7'h07;
			4'h8: light = 7'h7f;
			4'h9: light = 7'h6f;
			4'ha: light = 7'h77;
			4'hb: light = 7'h7c;
			4'hc: light = 7'h39;
			4'hd: light = 7'h5e;
			4'he: light = 7'h79;
			default: light = 7'h71;
		endcase
	end

endmodule

`default_nettype wire

/* logic/zhxpu_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module zhxpu_mem import zhxpu_pkg::*; #(
	parameter int BOOT_WORDS = 64,
	parameter int FLASH_WAIT = 3
) (
	input wire raw_clk,
	input wire rst_n,
	output flash_addr_t flash_addr,
	input word_t flash_data,
	output logic flash_ce,
	output logic flash_oe,
	output ram_addr_t ram_addr,
	output word_t ram_wdata,
	input word_t ram_rdata,
	output logic ram_en,
	output logic ram_oe,
	output logic ram_we,
	input wire data_need,
	input mem_req_t data_req,
	output logic data_done,
	output word_t data_rdata,
	input wire fetch_need,
	input ram_addr_t fetch_addr,
	output logic fetch_done,
	output word_t fetch_inst,
	output logic hold,
	output logic boot_done,
	output seg_t seg1,
	output seg_t seg2
);

	logic rd_req;
	flash_addr_t rd_addr;
	logic rd_done;
	word_t rd_data;
	logic boot_need;
	mem_req_t boot_req;
	logic boot_done_pulse;
	ram_addr_t boot_addr;
	logic [3:0] dig1_data;
	logic [3:0] dig2_data;

	flash_ctrl #(
		.FLASH_WAIT(FLASH_WAIT)
	) __flash_ctrl (
		.raw_clk(raw_clk),
		.rst_n(rst_n),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rd_done(rd_done),
		.rd_data(rd_data),
		.flash_addr(flash_addr),
		.flash_data(flash_data),
		.flash_ce(flash_ce),
		.flash_oe(flash_oe)
	);

	bootloader #(
		.BOOT_WORDS(BOOT_WORDS)
	) __bootloader (
		.raw_clk(raw_clk),
		.rst_n(rst_n),
		.rd_req(rd_req),
		.rd_addr(rd_addr),
		.rd_done(rd_done),
		.rd_data(rd_data),
		.boot_need(boot_need),
		.boot_req(boot_req),
		.boot_done_pulse(boot_done_pulse),
		.boot_done(boot_done),
		.boot_addr(boot_addr)
	);

	ram_ctrl __ram_ctrl (
		.raw_clk(raw_clk),
		.rst_n(rst_n),
		.boot_done(boot_done),
		.boot_need(boot_need),
		.boot_req(boot_req),
		.boot_done_pulse(boot_done_pulse),
		.data_need(data_need),
		.data_req(data_req),
		.data_done(data_done),
		.data_rdata(data_rdata),
		.fetch_need(fetch_need),
		.fetch_addr(fetch_addr),
		.fetch_done(fetch_done),
		.fetch_inst(fetch_inst),
		.hold(hold),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we)
	);

	// Boot address while booting, fetch address afterwards
	assign dig1_data = boot_done ? fetch_addr[7:4] : boot_addr[7:4];
	assign dig2_data = boot_done ? fetch_addr[3:0] : boot_addr[3:0];

	dig_ctrl __dig_ctrl_1 (
		.dig(dig1_data),
		.light(seg1)
	);

	dig_ctrl __dig_ctrl_2 (
		.dig(dig2_data),
		.light(seg2)
	);

endmodule

`default_nettype wire

/* test/zhxpu_mem_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module zhxpu_mem_checker (
	input wire raw_clk,
	input wire rst_n,
	input wire flash_ce,
	input wire flash_oe,
	input wire ram_en,
	input wire ram_oe,
	input wire ram_we,
	input wire boot_done_pulse,
	input wire data_done,
	input wire fetch_done,
	input wire boot_done,
	input wire hold
);

	int fails = 0;

	flash_oe_in_ce: assert property (@(posedge raw_clk) disable iff (!rst_n)
		flash_oe |-> flash_ce)
		else begin
			fails++;
			$error("flash_oe high while flash_ce is low");
		end

	ram_oe_we_apart: assert property (@(posedge raw_clk) disable iff (!rst_n)
		!(ram_oe && ram_we))
		else begin
			fails++;
			$error("ram_oe and ram_we high together");
		end

	// One SRAM access at a time, so one done per cycle
	single_done: assert property (@(posedge raw_clk) disable iff (!rst_n)
		$onehot0({boot_done_pulse, data_done, fetch_done}))
		else begin
			fails++;
			$error("two done pulses in the same cycle");
		end

	reset_state: assert property (@(posedge raw_clk)
		$rose(rst_n) |-> !flash_ce && !flash_oe && !ram_en && !ram_oe && !ram_we &&
			!boot_done_pulse && !data_done && !fetch_done && !boot_done && hold)
		else begin
			fails++;
			$error("control outputs not in reset state after reset");
		end

endmodule

`default_nettype wire

/* test/mem_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_scoreboard import zhxpu_pkg::*; #(
	parameter int BOOT_WORDS = 64
) (
	input wire raw_clk,
	input wire rst_n,
	input wire boot_done,
	input wire data_need,
	input mem_req_t data_req,
	input wire data_done,
	input word_t data_rdata,
	input wire fetch_need,
	input ram_addr_t fetch_addr,
	input wire fetch_done,
	input word_t fetch_inst,
	input wire [BOOT_WORDS*16-1:0] image,
	input wire [8*16-1:0] test_name,
	output int errors,
	output int checks
);

	// Shadow of every word written through the data port
	word_t shadow [0:(1<<18)-1];
	bit written [0:(1<<18)-1];
	mem_req_t data_open;
	ram_addr_t fetch_open;
	bit data_pending;
	bit fetch_pending;

	function automatic word_t expected_word(input ram_addr_t addr);
		if (written[addr])
			return shadow[addr];
		if (addr < BOOT_WORDS)
			return image[addr * 16 +: 16];
		return 16'h0000;
	endfunction

	task automatic compare(input string port, input ram_addr_t addr, input word_t actual);
		word_t exp;
		exp = expected_word(addr);
		checks++;
		if (actual !== exp) begin
			$display("[ERROR] %0s: %0s read at %05h expected %04h actual %04h",
				test_name, port, addr, exp, actual);
			errors++;
		end
	endtask

	initial begin
		errors = 0;
		checks = 0;
		data_pending = 0;
		fetch_pending = 0;
	end

	always @(posedge raw_clk) begin
		if (rst_n) begin
			if ((data_done || fetch_done) && !boot_done) begin
				$display("%0s: a CPU port was answered before boot finished", test_name);
				errors++;
			end
			if (data_done) begin
				if (!data_pending) begin
					$display("%0s: data_done pulsed with no data request open", test_name);
					errors++;
				end else if (data_open.we) begin
					shadow[data_open.addr] = data_open.wdata;
					written[data_open.addr] = 1'b1;
				end else begin
					compare("data", data_open.addr, data_rdata);
				end
				data_pending = 0;
			end else if (data_need && !data_pending) begin
				data_open = data_req;
				data_pending = 1;
			end
			if (fetch_done) begin
				if (!fetch_pending) begin
					$display("%0s: fetch_done pulsed with no fetch request open", test_name);
					errors++;
				end else begin
					compare("fetch", fetch_open, fetch_inst);
				end
				fetch_pending = 0;
			end else if (fetch_need && !fetch_pending) begin
				fetch_open = fetch_addr;
				fetch_pending = 1;
			end
		end
	end

endmodule

`default_nettype wire

/* test/tb_zhxpu_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_zhxpu_mem import zhxpu_pkg::*; ();

	localparam int BOOT_WORDS = 64;
	localparam int FLASH_WAIT = 3;
	localparam int N_WR = 8;
	localparam int N_MIX = 8;
	localparam int N_SEG = 8;
	localparam int REQ_TOTAL = 2 + BOOT_WORDS + 2 * N_WR + N_MIX + N_MIX / 2;
	localparam int REQ_LIMIT = 40;
	localparam int BOOT_LIMIT = 2 * BOOT_WORDS * (FLASH_WAIT + 6);
	localparam int WATCHDOG = 2 * (BOOT_WORDS * (FLASH_WAIT + 6) + 40 * REQ_TOTAL);
	// Glyphs from F down to 0 in gfedcba order
	localparam logic [16*7-1:0] GLYPHS = {
		7'h71, 7'h79, 7'h5e, 7'h39, 7'h7c, 7'h77, 7'h6f, 7'h7f,
		7'h07, 7'h7d, 7'h6d, 7'h66, 7'h4f, 7'h5b, 7'h06, 7'h3f
	};

	logic raw_clk;
	logic rst_n;
	flash_addr_t flash_addr;
	word_t flash_data;
	logic flash_ce;
	logic flash_oe;
	ram_addr_t ram_addr;
	word_t ram_wdata;
	word_t ram_rdata;
	logic ram_en;
	logic ram_oe;
	logic ram_we;
	logic data_need;
	mem_req_t data_req;
	logic data_done;
	word_t data_rdata;
	logic fetch_need;
	ram_addr_t fetch_addr;
	logic fetch_done;
	word_t fetch_inst;
	logic hold;
	logic boot_done;
	seg_t seg1;
	seg_t seg2;
	logic [BOOT_WORDS*16-1:0] flash_image;
	bit [15:0] sram [0:(1<<18)-1];
	logic [8*16-1:0] test_name;
	logic [31:0] rng;
	int sb_errors;
	int sb_checks;
	int tb_errors;
	int checks;
	int tests;
	int errs_at_start;

	initial raw_clk = 1'b0;
	always #50 raw_clk = ~raw_clk;

	// Flash answers only while selected
	assign flash_data = (flash_ce && flash_oe && flash_addr < BOOT_WORDS) ?
		flash_image[flash_addr * 16 +: 16] : 16'h0000;

	assign ram_rdata = (ram_en && ram_oe) ? word_t'(sram[ram_addr]) : 16'h0000;

	always @(posedge raw_clk) begin
		if (ram_en && ram_we)
			sram[ram_addr] <= ram_wdata;
	end

	zhxpu_mem #(
		.BOOT_WORDS(BOOT_WORDS),
		.FLASH_WAIT(FLASH_WAIT)
	) dut0 (
		.raw_clk(raw_clk),
		.rst_n(rst_n),
		.flash_addr(flash_addr),
		.flash_data(flash_data),
		.flash_ce(flash_ce),
		.flash_oe(flash_oe),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we),
		.data_need(data_need),
		.data_req(data_req),
		.data_done(data_done),
		.data_rdata(data_rdata),
		.fetch_need(fetch_need),
		.fetch_addr(fetch_addr),
		.fetch_done(fetch_done),
		.fetch_inst(fetch_inst),
		.hold(hold),
		.boot_done(boot_done),
		.seg1(seg1),
		.seg2(seg2)
	);

	mem_scoreboard #(
		.BOOT_WORDS(BOOT_WORDS)
	) sb0 (
		.raw_clk(raw_clk),
		.rst_n(rst_n),
		.boot_done(boot_done),
		.data_need(data_need),
		.data_req(data_req),
		.data_done(data_done),
		.data_rdata(data_rdata),
		.fetch_need(fetch_need),
		.fetch_addr(fetch_addr),
		.fetch_done(fetch_done),
		.fetch_inst(fetch_inst),
		.image(flash_image),
		.test_name(test_name),
		.errors(sb_errors),
		.checks(sb_checks)
	);

	bind zhxpu_mem zhxpu_mem_checker chk0 (
		.raw_clk(raw_clk),
		.rst_n(rst_n),
		.flash_ce(flash_ce),
		.flash_oe(flash_oe),
		.ram_en(ram_en),
		.ram_oe(ram_oe),
		.ram_we(ram_we),
		.boot_done_pulse(boot_done_pulse),
		.data_done(data_done),
		.fetch_done(fetch_done),
		.boot_done(boot_done),
		.hold(hold)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int error_total();
		return tb_errors + sb_errors + dut0.chk0.fails;
	endfunction

	task automatic start_test(input logic [8*16-1:0] name);
		test_name = name;
		errs_at_start = error_total();
	endtask

	task automatic finish_test();
		int n;
		n = error_total() - errs_at_start;
		tests++;
		$display("test %0s: %0s, %0d errors", test_name, (n == 0) ? "ok" : "FAILED", n);
	endtask

	task automatic raise_req(input bit dn, input mem_req_t dr, input bit fn,
		input ram_addr_t fa);
		@(negedge raw_clk);
		data_req = dr;
		data_need = dn;
		fetch_addr = fa;
		fetch_need = fn;
	endtask

	// Drops each request on the falling edge after its done
	task automatic wait_dones(output int data_at, output int fetch_at);
		int n;
		data_at = data_need ? -1 : 0;
		fetch_at = fetch_need ? -1 : 0;
		n = 0;
		while ((data_at < 0 || fetch_at < 0) && n < REQ_LIMIT) begin
			@(posedge raw_clk);
			n++;
			if (data_at < 0 && !data_done && !hold) begin
				$display("%0s: hold low while a data request is open", test_name);
				tb_errors++;
			end
			if (data_at < 0 && data_done)
				data_at = n;
			if (fetch_at < 0 && fetch_done)
				fetch_at = n;
			@(negedge raw_clk);
			if (data_at >= 0)
				data_need = 1'b0;
			if (fetch_at >= 0)
				fetch_need = 1'b0;
		end
		if (data_at < 0) begin
			$display("%0s: data request at %05h got no done within %0d cycles",
				test_name, data_req.addr, REQ_LIMIT);
			tb_errors++;
			data_need = 1'b0;
		end
		if (fetch_at < 0) begin
			$display("%0s: fetch request at %05h got no done within %0d cycles",
				test_name, fetch_addr, REQ_LIMIT);
			tb_errors++;
			fetch_need = 1'b0;
		end
	endtask

	initial begin
		int i;
		int n;
		int d_at;
		int f_at;
		mem_req_t req;
		ram_addr_t wr_addr;
		rst_n = 1'b0;
		data_need = 1'b0;
		data_req = '0;
		fetch_need = 1'b0;
		fetch_addr = '0;
		tb_errors = 0;
		checks = 0;
		tests = 0;
		test_name = "reset";
		wr_addr = ram_addr_t'(BOOT_WORDS);
		rng = 32'h33be;
		for (i = 0; i < BOOT_WORDS; i++) begin
			rng = lcg_next(rng);
			flash_image[i * 16 +: 16] = rng[31:16];
		end
		repeat (3) @(posedge raw_clk);
		@(negedge raw_clk);
		rst_n = 1'b1;

		start_test("boot");
		raise_req(1'b1, mem_req_t'{addr: 18'd5, wdata: 16'h0, we: 1'b0}, 1'b1, 18'd9);
		n = 0;
		while (!boot_done && n < BOOT_LIMIT) begin
			@(posedge raw_clk);
			n++;
			if (!boot_done && !hold) begin
				$display("boot: hold low before boot finished");
				tb_errors++;
			end
			if (!boot_done && (data_done || fetch_done)) begin
				$display("boot: a CPU port got a done before boot finished");
				tb_errors++;
			end
		end
		if (!boot_done) begin
			$display("boot: boot_done did not rise within %0d cycles", BOOT_LIMIT);
			tb_errors++;
		end
		wait_dones(d_at, f_at);
		finish_test();

		start_test("boot_image");
		for (i = 0; i < BOOT_WORDS; i++) begin
			req = '{addr: ram_addr_t'(i), wdata: 16'h0, we: 1'b0};
			raise_req(1'b1, req, 1'b0, fetch_addr);
			wait_dones(d_at, f_at);
		end
		finish_test();

		start_test("write_read");
		for (i = 0; i < N_WR; i++) begin
			rng = lcg_next(rng);
			wr_addr = ram_addr_t'(BOOT_WORDS) + ram_addr_t'(rng[27:12]);
			rng = lcg_next(rng);
			req = '{addr: wr_addr, wdata: rng[31:16], we: 1'b1};
			raise_req(1'b1, req, 1'b0, fetch_addr);
			wait_dones(d_at, f_at);
			req.we = 1'b0;
			raise_req(1'b1, req, 1'b0, fetch_addr);
			wait_dones(d_at, f_at);
		end
		finish_test();

		start_test("fetch_mix");
		for (i = 0; i < N_MIX; i++) begin
			rng = lcg_next(rng);
			req = '{addr: ram_addr_t'(rng[21:16]), wdata: 16'h0, we: 1'b0};
			if (i % 2 == 0) begin
				raise_req(1'b1, req, 1'b1, ram_addr_t'(rng[13:8]));
				wait_dones(d_at, f_at);
				checks++;
				if (d_at > f_at) begin
					$display("fetch_mix: fetch_done came before data_done with both pending");
					tb_errors++;
				end
			end else begin
				raise_req(1'b0, req, 1'b1, wr_addr);
				wait_dones(d_at, f_at);
			end
		end
		finish_test();

		start_test("display");
		for (i = 0; i < N_SEG; i++) begin
			rng = lcg_next(rng);
			@(negedge raw_clk);
			fetch_addr = ram_addr_t'(rng[29:12]);
			repeat (2) @(posedge raw_clk);
			checks += 2;
			if (seg1 !== GLYPHS[fetch_addr[7:4] * 7 +: 7]) begin
				$display("[ERROR] display: seg1 expected %02h actual %02h",
					GLYPHS[fetch_addr[7:4] * 7 +: 7], seg1);
				tb_errors++;
			end
			if (seg2 !== GLYPHS[fetch_addr[3:0] * 7 +: 7]) begin
				$display("[ERROR] display: seg2 expected %02h actual %02h",
					GLYPHS[fetch_addr[3:0] * 7 +: 7], seg2);
				tb_errors++;
			end
		end
		finish_test();

		$display("tests %0d, checks %0d, errors %0d", tests, checks + sb_checks, error_total());
		if (error_total() == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	initial begin
		repeat (WATCHDOG) @(posedge raw_clk);
		$display("watchdog: run did not end within %0d cycles", WATCHDOG);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
logic/zhxpu_pkg.sv
logic/flash_ctrl.sv
logic/bootloader.sv
logic/ram_ctrl.sv
logic/dig_ctrl.sv
logic/zhxpu_mem.sv
test/zhxpu_mem_checker.sv
test/mem_scoreboard.sv
test/tb_zhxpu_mem.sv

/* Bender.yml */
package:
  name: zhxpu_mem

sources:
  - logic/zhxpu_pkg.sv
  - logic/flash_ctrl.sv
  - logic/bootloader.sv
  - logic/ram_ctrl.sv
  - logic/dig_ctrl.sv
  - logic/zhxpu_mem.sv
  - target: test
    files:
      - test/zhxpu_mem_checker.sv
      - test/mem_scoreboard.sv
      - test/tb_zhxpu_mem.sv
